//--- files.f
verilog/lsu_pkg.sv
verilog/ls_buffer.sv
verilog/mem_stage.sv
verilog/data_mem.sv
verilog/lsu_top.sv
tests/lsu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the load/store unit testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --top-module lsu_tb -f files.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vlsu_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "sim failed" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if ! grep -q "sim passed" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi

exit 0

//--- tests/lsu_tb.sv
// **********************************************************
// testbench for the load/store unit. a table of dispatch,
// broadcast, flush and rob_head rows is applied in a loop.
// each row may expect a load result, a store completion, a
// quiet window or a level of full. load values come from a
// word model of memory that the store rows keep up to date
// **********************************************************

`timescale 1ns/1ps

module lsu_tb
    import lsu_pkg::*;
;

    localparam int EVENT_TIMEOUT = 200;
    localparam int QUIET_CYCLES = 30;
    localparam int MAX_ROWS = 64;

    typedef enum logic [2:0] {
        act_disp,
        act_ext,
        act_flush,
        act_head,
        act_wait
    } act_e;

    typedef enum logic [2:0] {
        exp_none,
        exp_load,
        exp_store,
        exp_quiet,
        exp_full,
        exp_not_full
    } exp_e;

    typedef struct packed {
        act_e           act;
        lsb_entry_t     ent;
        rob_tag_t       tag;
        logic [31:0]    value;
        exp_e           exp;
        rob_tag_t       exp_tag;
        logic [7:0]     exp_word;
    } row_t;

    // one completion seen on the unit outputs
    typedef struct packed {
        logic           is_store;
        rob_tag_t       tag;
        logic [31:0]    value;
    } event_t;

    logic           clk;
    logic           rst_n;
    logic           flush;
    logic           dispatch_valid;
    lsb_entry_t     dispatch;
    rob_tag_t       rob_head;
    cdb_t           cdb_ext;
    logic           full;
    cdb_t           cdb_load;
    logic           st_done;
    rob_tag_t       st_tag;

    row_t           table_rows [MAX_ROWS];
    int             n_rows;
    logic [31:0]    model [256];
    event_t         events [$];
    integer         seed;

    lsu_top lsu_top_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush          (flush),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .rob_head       (rob_head),
        .cdb_ext        (cdb_ext),
        .full           (full),
        .cdb_load       (cdb_load),
        .st_done        (st_done),
        .st_tag         (st_tag)
    );

    always #2 clk = ~clk;

    // completions are collected mid-cycle where outputs are stable
    always @(negedge clk) begin
        if (rst_n && cdb_load.valid) begin
            events.push_back('{is_store: 1'b0, tag: cdb_load.tag, value: cdb_load.value});
        end
        if (rst_n && st_done) begin
            events.push_back('{is_store: 1'b1, tag: st_tag, value: 32'h0});
        end
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            stop_run($sformatf("Error: %s is %h, expected %h", name, actual, expected));
        end
    endtask

    // inputs only change 1 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic next_event(output event_t ev);
        int waited;
        waited = 0;
        while (events.size() == 0 && waited < EVENT_TIMEOUT) begin
            step();
            waited++;
        end
        if (events.size() == 0) begin
            stop_run("no load result or store completion arrived before the timeout");
        end else begin
            ev = events.pop_front();
        end
    endtask

    task automatic add_disp(input ls_op_e op, input rob_tag_t tag, input rob_tag_t base_tag,
                            input logic [31:0] base_val, input logic [31:0] data,
                            input logic [31:0] imm, input exp_e exp,
                            input rob_tag_t exp_tag, input logic [7:0] exp_word);
        row_t r;
        r = '0;
        r.act = act_disp;
        r.ent = '{op: op, tag: tag, base_tag: base_tag, base_val: base_val,
                  data_tag: '0, data_val: data, imm: imm};
        r.exp = exp;
        r.exp_tag = exp_tag;
        r.exp_word = exp_word;
        table_rows[n_rows] = r;
        n_rows++;
    endtask

    task automatic add_act(input act_e act, input rob_tag_t tag, input logic [31:0] value,
                           input exp_e exp, input rob_tag_t exp_tag,
                           input logic [7:0] exp_word);
        row_t r;
        r = '0;
        r.act = act;
        r.tag = tag;
        r.value = value;
        r.exp = exp;
        r.exp_tag = exp_tag;
        r.exp_word = exp_word;
        table_rows[n_rows] = r;
        n_rows++;
    endtask

    task automatic build_table();
        logic [31:0] ptr;
        n_rows = 0;
        // store held back until rob_head reaches its tag
        add_disp(op_sw, 5'd5, 5'd0, 32'h40, $random(seed), 32'h0, exp_quiet, 5'd0, 8'h0);
        add_act(act_head, 5'd5, 32'h0, exp_store, 5'd5, 8'h0);
        // load of the word just stored
        add_disp(op_lw, 5'd6, 5'd0, 32'h40, 32'h0, 32'h0, exp_load, 5'd6, 8'h10);
        // base arrives later on the external bus
        add_act(act_head, 5'd8, 32'h0, exp_none, 5'd0, 8'h0);
        add_disp(op_sw, 5'd8, 5'd0, 32'h100, $random(seed), 32'h8, exp_store, 5'd8, 8'h0);
        add_disp(op_lw, 5'd9, 5'd7, 32'h0, 32'h0, 32'h8, exp_quiet, 5'd0, 8'h0);
        add_act(act_ext, 5'd7, 32'h100, exp_load, 5'd9, 8'h42);
        // pointer chase, second load's base is the first load's value
        ptr = $random(seed);
        ptr[9:2] = 8'h30;
        add_act(act_head, 5'd11, 32'h0, exp_none, 5'd0, 8'h0);
        add_disp(op_sw, 5'd11, 5'd0, 32'h80, ptr, 32'h0, exp_store, 5'd11, 8'h0);
        add_act(act_head, 5'd12, 32'h0, exp_none, 5'd0, 8'h0);
        add_disp(op_sw, 5'd12, 5'd0, 32'hc4, $random(seed), 32'h0, exp_store, 5'd12, 8'h0);
        add_disp(op_lw, 5'd13, 5'd0, 32'h80, 32'h0, 32'h0, exp_none, 5'd0, 8'h0);
        add_disp(op_lw, 5'd14, 5'd13, 32'h0, 32'h0, 32'h4, exp_load, 5'd13, 8'h20);
        add_act(act_wait, 5'd0, 32'h0, exp_load, 5'd14, 8'h31);
        // fill with waiting loads, then flush them away
        for (int i = 0; i < LSB_DEPTH; i++) begin
            add_disp(op_lw, 5'(16 + i), 5'(24 + i), 32'h0, 32'h0, 32'h0,
                     (i == LSB_DEPTH - 1) ? exp_full : exp_none, 5'd0, 8'h0);
        end
        add_act(act_flush, 5'd0, 32'h0, exp_not_full, 5'd0, 8'h0);
        add_act(act_ext, 5'd24, 32'h0, exp_none, 5'd0, 8'h0);
        add_act(act_ext, 5'd25, 32'h40, exp_quiet, 5'd0, 8'h0);
    endtask

    task automatic apply_row(input row_t r);
        event_t ev;
        logic [31:0] addr;
        case (r.act)
            act_disp: begin
                dispatch_valid = 1'b1;
                dispatch = r.ent;
                if (r.ent.op == op_sw) begin
                    addr = r.ent.base_val + r.ent.imm;
                    model[addr[9:2]] = r.ent.data_val;
                end
            end
            act_ext: cdb_ext = '{valid: 1'b1, tag: r.tag, value: r.value};
            act_flush: flush = 1'b1;
            act_head: rob_head = r.tag;
            default: ;
        endcase
        step();
        dispatch_valid = 1'b0;
        dispatch = '0;
        cdb_ext = '0;
        flush = 1'b0;
        case (r.exp)
            exp_load: begin
                next_event(ev);
                check("st_done", 32'(ev.is_store), 32'h0);
                check("cdb_load.tag", 32'(ev.tag), 32'(r.exp_tag));
                check("cdb_load.value", ev.value, model[r.exp_word]);
            end
            exp_store: begin
                next_event(ev);
                check("st_done", 32'(ev.is_store), 32'h1);
                check("st_tag", 32'(ev.tag), 32'(r.exp_tag));
            end
            exp_quiet: begin
                repeat (QUIET_CYCLES) step();
                if (events.size() != 0) begin
                    stop_run("a completion appeared during a window that should stay quiet");
                end
            end
            exp_full: check("full", 32'(full), 32'h1);
            exp_not_full: check("full", 32'(full), 32'h0);
            default: ;
        endcase
    endtask

    initial begin
        seed = 32'h3e27_d76f;
        clk = 1'b0;
        rst_n = 1'b0;
        flush = 1'b0;
        dispatch_valid = 1'b0;
        dispatch = '0;
        rob_head = '0;
        cdb_ext = '0;
        build_table();
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        step();
        check("full", 32'(full), 32'h0);
        check("cdb_load.valid", 32'(cdb_load.valid), 32'h0);
        check("st_done", 32'(st_done), 32'h0);
        for (int i = 0; i < n_rows; i++) begin
            apply_row(table_rows[i]);
        end
        if (events.size() != 0) begin
            stop_run("completions were left over after the last table row");
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

//--- verilog/lsu_top.sv
// **********************************************************
// load/store unit top. buffer, memory stage and data memory
// in a two-stage chain; the load result bus leaves the unit
// and also feeds back into the buffer for waiting operands
// **********************************************************

`timescale 1ns/1ps

module lsu_top
    import lsu_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        flush,
    input  logic        dispatch_valid,
    input  lsb_entry_t  dispatch,
    input  rob_tag_t    rob_head,
    input  cdb_t        cdb_ext,
    output logic        full,
    output cdb_t        cdb_load,
    output logic        st_done,
    output rob_tag_t    st_tag
);

    // buffer to stage
    logic                   issue_valid;
    mem_op_t                issue;
    logic                   mem_busy;

    // stage to memory
    logic                   mem_req;
    logic                   mem_we;
    logic [MEM_ADDR_W-1:0]  mem_addr;
    logic [DATA_W-1:0]      mem_wdata;
    logic                   mem_ack;
    logic [DATA_W-1:0]      mem_rdata;

    ls_buffer ls_buffer_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush          (flush),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .rob_head       (rob_head),
        .cdb_ext        (cdb_ext),
        .cdb_load       (cdb_load),
        .mem_busy       (mem_busy),
        .full           (full),
        .issue_valid    (issue_valid),
        .issue          (issue)
    );

    mem_stage mem_stage_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .issue_valid (issue_valid),
        .issue       (issue),
        .mem_ack     (mem_ack),
        .mem_rdata   (mem_rdata),
        .mem_busy    (mem_busy),
        .mem_req     (mem_req),
        .mem_we      (mem_we),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .cdb_load    (cdb_load),
        .st_done     (st_done),
        .st_tag      (st_tag)
    );

    data_mem data_mem_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

endmodule

//--- verilog/data_mem.sv
// **********************************************************
// word-addressed data memory behind a four-phase handshake.
// ack follows req by one cycle in both directions; a write
// lands and read data is registered as ack rises
// **********************************************************

`timescale 1ns/1ps

module data_mem
    import lsu_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    mem_req,
    input  logic                    mem_we,
    input  logic [MEM_ADDR_W-1:0]   mem_addr,
    input  logic [DATA_W-1:0]       mem_wdata,
    output logic                    mem_ack,
    output logic [DATA_W-1:0]       mem_rdata
);

    logic [DATA_W-1:0]  mem [2**MEM_ADDR_W];
    logic               req_rise;

    // new request seen, ack goes high on this edge
    assign req_rise = mem_req && !mem_ack;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_ack <= 1'b0;
        end else begin
            mem_ack <= mem_req;
        end
    end

    // storage and read data
    always_ff @(posedge clk) begin
        if (req_rise && mem_we) begin
            mem[mem_addr] <= mem_wdata;
        end
        if (req_rise && !mem_we) begin
            mem_rdata <= mem[mem_addr];
        end
    end

endmodule

//--- verilog/mem_stage.sv
// **********************************************************
// memory stage of the load/store unit. takes one issued
// operation at a time, forms the word address and runs the
// four-phase req/ack handshake with data memory. loads end
// with a broadcast on the load bus, stores with st_done
// **********************************************************

`timescale 1ns/1ps

module mem_stage
    import lsu_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    flush,
    input  logic                    issue_valid,
    input  mem_op_t                 issue,
    input  logic                    mem_ack,
    input  logic [DATA_W-1:0]       mem_rdata,
    output logic                    mem_busy,
    output logic                    mem_req,
    output logic                    mem_we,
    output logic [MEM_ADDR_W-1:0]   mem_addr,
    output logic [DATA_W-1:0]       mem_wdata,
    output cdb_t                    cdb_load,
    output logic                    st_done,
    output rob_tag_t                st_tag
);

    // sequencer state and the operation in flight
    mem_state_e             state;
    mem_op_t                op_q;
    logic [DATA_W-1:0]      rdata_q;
    logic [DATA_W-1:0]      byte_addr;
    logic                   flushed;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= st_idle;
            flushed <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (issue_valid) begin
                        state   <= st_req;
                        flushed <= flush;
                    end
                end
                st_req: begin
                    flushed <= flushed | flush;
                    if (mem_ack) begin
                        state <= st_release;
                    end
                end
                st_release: begin
                    flushed <= flushed | flush;
                    // wait for memory to drop ack
                    if (!mem_ack) begin
                        state <= lsu_pkg::st_done;
                    end
                end
                lsu_pkg::st_done: begin
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // operation and read data
    always_ff @(posedge clk) begin
        if (state == st_idle && issue_valid) begin
            op_q <= issue;
        end
        if (state == st_req && mem_ack) begin
            rdata_q <= mem_rdata;
        end
    end

    assign byte_addr = op_q.base_val + op_q.imm;
    assign mem_addr  = byte_addr[MEM_ADDR_W+1:2];
    assign mem_wdata = op_q.data_val;
    assign mem_we    = (op_q.op == op_sw);
    assign mem_req   = (state == st_req);
    assign mem_busy  = (state != st_idle);

    // flushed loads finish the handshake but stay silent
    always_comb begin
        cdb_load.valid = (state == lsu_pkg::st_done) && (op_q.op == op_lw) && !flushed;
        cdb_load.tag   = op_q.tag;
        cdb_load.value = rdata_q;
    end

    assign st_done = (state == lsu_pkg::st_done) && (op_q.op == op_sw);
    assign st_tag  = op_q.tag;

endmodule

//--- verilog/ls_buffer.sv
// **********************************************************
// circular load/store buffer. takes dispatched operations at
// the tail, resolves waiting operands from the external bus
// and the load result bus, and issues only the oldest entry.
// stores leave only when their tag is the reorder buffer head
// **********************************************************

`timescale 1ns/1ps

module ls_buffer
    import lsu_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        flush,
    input  logic        dispatch_valid,
    input  lsb_entry_t  dispatch,
    input  rob_tag_t    rob_head,
    input  cdb_t        cdb_ext,
    input  cdb_t        cdb_load,
    input  logic        mem_busy,
    output logic        full,
    output logic        issue_valid,
    output mem_op_t     issue
);

    lsb_entry_t             entries [LSB_DEPTH];
    logic [LSB_DEPTH-1:0]   busy;
    logic [LSB_IDX_W-1:0]   head;
    logic [LSB_IDX_W-1:0]   tail;
    logic [LSB_IDX_W:0]     count;
    logic [LSB_IDX_W:0]     count_next;

    lsb_entry_t             head_entry;
    logic                   head_ready;
    logic                   do_dispatch;
    logic                   can_issue;

    // a valid broadcast with a real tag that matches the waiting operand
    function automatic logic bus_hit(rob_tag_t wait_tag, cdb_t bus);
        return bus.valid && (bus.tag != '0) && (bus.tag == wait_tag);
    endfunction

    // resolve base and data of one record, external bus first
    function automatic lsb_entry_t snoop(lsb_entry_t e, cdb_t ext, cdb_t ld);
        lsb_entry_t r;
        r = e;
        if (bus_hit(e.base_tag, ext)) begin
            r.base_tag = '0;
            r.base_val = ext.value;
        end else if (bus_hit(e.base_tag, ld)) begin
            r.base_tag = '0;
            r.base_val = ld.value;
        end
        if (bus_hit(e.data_tag, ext)) begin
            r.data_tag = '0;
            r.data_val = ext.value;
        end else if (bus_hit(e.data_tag, ld)) begin
            r.data_tag = '0;
            r.data_val = ld.value;
        end
        return r;
    endfunction

    assign head_entry = entries[head];
    assign do_dispatch = dispatch_valid && !full;

    // loads need only the base; stores need both operands and commit
    always_comb begin
        head_ready = busy[head] && (head_entry.base_tag == '0);
        if (head_entry.op == op_sw) begin
            head_ready = head_ready && (head_entry.data_tag == '0)
                         && (head_entry.tag == rob_head);
        end
    end

    // the stage only reports busy from the cycle after the pulse
    assign can_issue = head_ready && !mem_busy && !issue_valid;

    always_comb begin
        count_next = count;
        if (do_dispatch && !can_issue) begin
            count_next = count + 1'b1;
        end else if (!do_dispatch && can_issue) begin
            count_next = count - 1'b1;
        end
    end

    // control state, cleared by reset or flush
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            busy        <= '0;
            head        <= '0;
            tail        <= '0;
            count       <= '0;
            full        <= 1'b0;
            issue_valid <= 1'b0;
        end else begin
            if (do_dispatch) begin
                busy[tail] <= 1'b1;
                tail       <= tail + 1'b1;
            end
            if (can_issue) begin
                busy[head] <= 1'b0;
                head       <= head + 1'b1;
            end
            count       <= count_next;
            full        <= (count_next == LSB_DEPTH);
            issue_valid <= can_issue;
        end
    end

    // entry payload; a new entry also sees this cycle's broadcasts
    always_ff @(posedge clk) begin
        for (int i = 0; i < LSB_DEPTH; i++) begin
            if (busy[i]) begin
                entries[i] <= snoop(entries[i], cdb_ext, cdb_load);
            end
        end
        if (do_dispatch) begin
            entries[tail] <= snoop(dispatch, cdb_ext, cdb_load);
        end
    end

    // issued operation, held until the next pulse
    always_ff @(posedge clk) begin
        if (can_issue) begin
            issue <= '{
                op:       head_entry.op,
                tag:      head_entry.tag,
                base_val: head_entry.base_val,
                imm:      head_entry.imm,
                data_val: head_entry.data_val
            };
        end
    end

endmodule

//--- verilog/lsu_pkg.sv
// **********************************************************
// shared widths, tag type, opcodes and records of the
// load/store unit. every module and the testbench pull these
// in with a wildcard import in the module header
// **********************************************************

package lsu_pkg;

    // data path and tag widths
    localparam int DATA_W = 32;
    localparam int TAG_W = 5;

    // buffer geometry
    localparam int LSB_DEPTH = 8;
    localparam int LSB_IDX_W = 3;

    // 256 words, byte address bits 9:2
    localparam int MEM_ADDR_W = 8;

    // reorder buffer tag, zero means no producer
    typedef logic [TAG_W-1:0] rob_tag_t;

    typedef enum logic {
        op_lw = 1'b0,
        op_sw = 1'b1
    } ls_op_e;

    // record written through the dispatch port
    typedef struct packed {
        ls_op_e              op;
        rob_tag_t            tag;
        rob_tag_t            base_tag;
        logic [DATA_W-1:0]   base_val;
        rob_tag_t            data_tag;
        logic [DATA_W-1:0]   data_val;
        logic [DATA_W-1:0]   imm;
    } lsb_entry_t;

    // result broadcast, both the external bus and the load bus
    typedef struct packed {
        logic                valid;
        rob_tag_t            tag;
        logic [DATA_W-1:0]   value;
    } cdb_t;

    // operation handed from the buffer head to the memory stage
    typedef struct packed {
        ls_op_e              op;
        rob_tag_t            tag;
        logic [DATA_W-1:0]   base_val;
        logic [DATA_W-1:0]   imm;
        logic [DATA_W-1:0]   data_val;
    } mem_op_t;

    // memory stage sequence, one pass per issued operation
    typedef enum logic [1:0] {
        st_idle    = 2'd0,
        st_req     = 2'd1,
        st_release = 2'd2,
        st_done    = 2'd3
    } mem_state_e;

endpackage
